// ==== common/hex_mul_pkg.sv ====
package hex_mul_pkg;

  // operands and product of the signed multiplier
  typedef logic signed [31:0] operand_t;
  typedef logic signed [53:0] product_t;

  // packed word shown on screen: product (sign-extended) | a | b
  typedef logic [127:0] display_t;

  // rgb565 pixel
  typedef logic [15:0] color_t;

  // pixel coordinate on the panel
  typedef logic [7:0] coord_t;

  // lcd streamer states
  typedef enum logic [1:0] {
    st_reset,   // panel held in reset
    st_init,    // fixed start-up commands
    st_pixels   // frame loop
  } lcd_state_t;

  // operand values after reset
  parameter operand_t c_ma_init = 32'sd39127620;
  parameter operand_t c_mb_init = 32'sd35792620;

  // text colours
  parameter color_t c_fg_color = 16'hffff; // white
  parameter color_t c_bg_color = 16'h0000; // black

endpackage

// ==== source/btn_debounce.sv ====
`timescale 1ns/10ps

module btn_debounce #(
  parameter int c_debounce_bits = 20
) (
  input  logic       clkm,
  input  logic       reset,
  input  logic [6:0] btn,
  output logic [6:0] rising
);

  logic [6:0] btn_meta;                      // first sync stage
  logic [6:0] btn_sync;                      // second sync stage
  logic [6:0] btn_state;                     // debounced level
  logic [c_debounce_bits-1:0] stable_cnt [7];

  always_ff @(posedge clkm)
  begin
    if (reset)
    begin
      btn_meta  <= '0;
      btn_sync  <= '0;
      btn_state <= '0;
      rising    <= '0;
      for (int i = 0; i < 7; i++)
      begin
        stable_cnt[i] <= '0;
      end
    end
    else
    begin
      btn_meta <= btn;
      btn_sync <= btn_meta;
      for (int i = 0; i < 7; i++)
      begin
        rising[i] <= 1'b0;
        if (btn_sync[i] == btn_state[i])
        begin
          stable_cnt[i] <= '0; // input agrees, start over
        end
        else if (&stable_cnt[i])
        begin
          // level held long enough, take it
          btn_state[i]  <= btn_sync[i];
          stable_cnt[i] <= '0;
          rising[i]     <= btn_sync[i]; // pulse only on 0 -> 1
        end
        else
        begin
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/operand_multiplier.sv ====
`timescale 1ns/10ps

module operand_multiplier (
  input  logic                  clkm,
  input  logic                  reset,
  input  logic [6:0]            rising,
  output hex_mul_pkg::display_t display,
  output logic [7:0]            product_low
);

  import hex_mul_pkg::*;

  operand_t ma;        // operand a
  operand_t mb;        // operand b
  operand_t ma_s1;
  operand_t mb_s1;
  operand_t ma_s2;     // kept aligned with the product
  operand_t mb_s2;
  product_t product;

  // operand step registers, up wins over down
  always_ff @(posedge clkm)
  begin
    if (reset)
    begin
      ma <= c_ma_init;
      mb <= c_mb_init;
    end
    else
    begin
      if (rising[3])
        ma <= ma + 32'sd1;
      else if (rising[4])
        ma <= ma - 32'sd1;
      if (rising[6])
        mb <= mb + 32'sd1;
      else if (rising[5])
        mb <= mb - 32'sd1;
    end
  end

  // two-stage pipeline, runs every cycle
  always_ff @(posedge clkm)
  begin
    ma_s1   <= ma;
    mb_s1   <= mb;
    product <= product_t'(ma_s1) * product_t'(mb_s1); // sign-extend before multiply
    ma_s2   <= ma_s1;
    mb_s2   <= mb_s1;
  end

  // product on top, then a, then b
  assign display     = {{10{product[53]}}, product, ma_s2, mb_s2};
  assign product_low = product[7:0];

endmodule

// ==== hex_display/hex_decoder.sv ====
`timescale 1ns/10ps

module hex_decoder #(
  parameter int c_row_digits = 16
) (
  input  hex_mul_pkg::display_t data,
  input  hex_mul_pkg::coord_t   x,
  input  hex_mul_pkg::coord_t   y,
  output hex_mul_pkg::color_t   color
);

  import hex_mul_pkg::*;

  int          col;        // digit column
  int          sub_x;      // pixel inside the cell, 0 is spacing
  int          row;        // text row
  int          line;       // glyph line inside the cell
  int          nib_idx;    // nibble counted from the msb
  logic [3:0]  nibble;
  logic [34:0] glyph;
  logic [4:0]  glyph_row;

  // 5x7 glyphs, top line first, bit 4 is the leftmost pixel
  function automatic logic [34:0] font_rows(input logic [3:0] n);
    case (n)
      4'h0: font_rows = {5'h0e, 5'h11, 5'h13, 5'h15, 5'h19, 5'h11, 5'h0e};
      4'h1: font_rows = {5'h04, 5'h0c, 5'h04, 5'h04, 5'h04, 5'h04, 5'h0e};
      4'h2: font_rows = {5'h0e, 5'h11, 5'h01, 5'h02, 5'h04, 5'h08, 5'h1f};
      4'h3: font_rows = {5'h1f, 5'h02, 5'h04, 5'h02, 5'h01, 5'h11, 5'h0e};
      4'h4: font_rows = {5'h02, 5'h06, 5'h0a, 5'h12, 5'h1f, 5'h02, 5'h02};
      4'h5: font_rows = {5'h1f, 5'h10, 5'h1e, 5'h01, 5'h01, 5'h11, 5'h0e};
      4'h6: font_rows = {5'h06, 5'h08, 5'h10, 5'h1e, 5'h11, 5'h11, 5'h0e};
      4'h7: font_rows = {5'h1f, 5'h01, 5'h02, 5'h04, 5'h08, 5'h08, 5'h08};
      4'h8: font_rows = {5'h0e, 5'h11, 5'h11, 5'h0e, 5'h11, 5'h11, 5'h0e};
      4'h9: font_rows = {5'h0e, 5'h11, 5'h11, 5'h0f, 5'h01, 5'h02, 5'h0c};
      4'ha: font_rows = {5'h0e, 5'h11, 5'h11, 5'h11, 5'h1f, 5'h11, 5'h11};
      4'hb: font_rows = {5'h1e, 5'h11, 5'h11, 5'h1e, 5'h11, 5'h11, 5'h1e};
      4'hc: font_rows = {5'h0e, 5'h11, 5'h10, 5'h10, 5'h10, 5'h11, 5'h0e};
      4'hd: font_rows = {5'h1c, 5'h12, 5'h11, 5'h11, 5'h11, 5'h12, 5'h1c};
      4'he: font_rows = {5'h1f, 5'h10, 5'h10, 5'h1e, 5'h10, 5'h10, 5'h1f};
      default: font_rows = {5'h1f, 5'h10, 5'h10, 5'h1e, 5'h10, 5'h10, 5'h10};
    endcase
  endfunction

  always_comb
  begin
    col     = int'(x) / 6;
    sub_x   = int'(x) % 6;
    row     = int'(y) / 8;
    line    = int'(y) % 8;
    nib_idx = row * c_row_digits + col;

    // pick the nibble only inside the text area
    if (col < c_row_digits && nib_idx < 32)
      nibble = data[127 - 4 * nib_idx -: 4];
    else
      nibble = 4'h0;

    glyph = font_rows(nibble);
    if (line < 7)
      glyph_row = glyph[34 - 5 * line -: 5];
    else
      glyph_row = 5'h00; // gap below the glyph

    color = c_bg_color;
    if (col < c_row_digits && nib_idx < 32 && sub_x != 0)
    begin
      if (glyph_row[5 - sub_x])
        color = c_fg_color;
    end
  end

endmodule

// ==== lcd/lcd_stream.sv ====
`timescale 1ns/10ps

module lcd_stream #(
  parameter int c_width  = 240,
  parameter int c_height = 240
) (
  input  logic                clkm,
  input  logic                reset,
  input  hex_mul_pkg::color_t color,
  output hex_mul_pkg::coord_t x,
  output hex_mul_pkg::coord_t y,
  output logic                next_pixel,
  output logic                spi_clk,
  output logic                spi_mosi,
  output logic                spi_dc,
  output logic                spi_resn,
  output logic                spi_csn
);

  import hex_mul_pkg::*;

  localparam int c_init_len = 15; // entries in the start-up table

  lcd_state_t  state;
  logic [3:0]  hold_cnt;   // cycles after reset with the panel in reset
  logic [3:0]  init_idx;
  logic [4:0]  hc;         // half-bit counter within the current item
  logic [4:0]  last_hc;
  logic [15:0] shreg;      // outgoing bits, msb first
  logic        cur_dc;     // dc level for the current item
  logic        cur_16;     // item is a 16-bit pixel
  logic        need_ram;   // memory-write owed before the next frame
  logic        fetch;

  // {dc, byte}
  function automatic logic [8:0] init_entry(input logic [3:0] idx);
    case (idx)
      4'd0:    init_entry = {1'b0, 8'h11};             // sleep out
      4'd1:    init_entry = {1'b0, 8'h3a};             // colour mode
      4'd2:    init_entry = {1'b1, 8'h55};             // 16 bit/pixel
      4'd3:    init_entry = {1'b0, 8'h29};             // display on
      4'd4:    init_entry = {1'b0, 8'h2a};             // column set
      4'd8:    init_entry = {1'b1, 8'(c_width - 1)};
      4'd9:    init_entry = {1'b0, 8'h2b};             // row set
      4'd13:   init_entry = {1'b1, 8'(c_height - 1)};
      4'd14:   init_entry = {1'b0, 8'h2c};             // memory write
      default: init_entry = {1'b1, 8'h00};             // zero address bytes
    endcase
  endfunction

  assign last_hc    = cur_16 ? 5'd31 : 5'd15;
  assign fetch      = (state == st_reset) ? (hold_cnt == 4'd15) : (hc == last_hc);
  assign next_pixel = (state == st_pixels) && !need_ram && (hc == last_hc);
  assign spi_csn    = 1'b1; // panel has no chip select wired

  always_ff @(posedge clkm)
  begin
    if (reset)
    begin
      state    <= st_reset;
      hold_cnt <= '0;
      init_idx <= '0;
      hc       <= '0;
      need_ram <= 1'b0;
      x        <= '0;
      y        <= '0;
      spi_clk  <= 1'b1; // mode 3 idles high
      spi_mosi <= 1'b0;
      spi_dc   <= 1'b0;
      spi_resn <= 1'b0;
    end
    else
    begin
      if (state == st_reset)
        hold_cnt <= hold_cnt + 1'b1;
      else
      begin
        hc <= hc + 1'b1;
        if (!hc[0])
        begin
          // falling edge, next bit out
          spi_clk  <= 1'b0;
          spi_mosi <= shreg[15];
          shreg    <= {shreg[14:0], 1'b0};
          if (hc == 5'd0)
            spi_dc <= cur_dc;
        end
        else
          spi_clk <= 1'b1; // panel samples here
      end

      if (fetch)
      begin
        hc <= '0;
        if (state == st_pixels)
        begin
          if (need_ram)
          begin
            shreg    <= {8'h2c, 8'h00};
            cur_dc   <= 1'b0;
            cur_16   <= 1'b0;
            need_ram <= 1'b0;
          end
          else
          begin
            shreg  <= color; // colour of the current x, y
            cur_dc <= 1'b1;
            cur_16 <= 1'b1;
            if (x == coord_t'(c_width - 1))
            begin
              x <= '0;
              if (y == coord_t'(c_height - 1))
              begin
                y        <= '0;
                need_ram <= 1'b1; // frame done
              end
              else
                y <= y + 1'b1;
            end
            else
              x <= x + 1'b1;
          end
        end
        else
        begin
          {cur_dc, shreg[15:8]} <= init_entry(init_idx);
          shreg[7:0] <= 8'h00;
          cur_16     <= 1'b0;
          init_idx   <= init_idx + 1'b1;
          spi_resn   <= 1'b1;
          if (init_idx == 4'(c_init_len - 1))
            state <= st_pixels;
          else
            state <= st_init;
        end
      end
    end
  end

endmodule

// ==== source/top_hex_mul.sv ====
`timescale 1ns/10ps

module top_hex_mul #(
  parameter int c_debounce_bits = 20,
  parameter int c_width         = 240,
  parameter int c_height        = 240,
  parameter int c_row_digits    = 16
) (
  input  logic       clkm,
  input  logic       reset,
  input  logic [6:0] btn,
  output logic [7:0] led,
  output logic       oled_clk,
  output logic       oled_mosi,
  output logic       oled_dc,
  output logic       oled_resn,
  output logic       oled_csn
);

  import hex_mul_pkg::*;

  logic [6:0] btn_rising;
  display_t   display;
  coord_t     x;
  coord_t     y;
  color_t     color;

  btn_debounce #(
    .c_debounce_bits(c_debounce_bits)
  ) btn_debounce_i (
    .clkm   (clkm),
    .reset  (reset),
    .btn    (btn),
    .rising (btn_rising)
  );

  operand_multiplier operand_multiplier_i (
    .clkm        (clkm),
    .reset       (reset),
    .rising      (btn_rising),
    .display     (display),
    .product_low (led)          // low product byte on the leds
  );

  hex_decoder #(
    .c_row_digits(c_row_digits)
  ) hex_decoder_i (
    .data  (display),
    .x     (x),
    .y     (y),
    .color (color)
  );

  lcd_stream #(
    .c_width  (c_width),
    .c_height (c_height)
  ) lcd_stream_i (
    .clkm       (clkm),
    .reset      (reset),
    .color      (color),
    .x          (x),
    .y          (y),
    .next_pixel (),
    .spi_clk    (oled_clk),
    .spi_mosi   (oled_mosi),
    .spi_dc     (oled_dc),
    .spi_resn   (oled_resn),
    .spi_csn    (oled_csn)
  );

endmodule

// ==== dv/tb_top_hex_mul.sv ====
`timescale 1ns/10ps

module tb_top_hex_mul;

  import hex_mul_pkg::*;

  localparam int c_debounce_bits  = 3;
  localparam int c_width          = 12;
  localparam int c_height         = 8;
  localparam int c_frame_bits     = c_width * c_height * 16;
  localparam int c_release_cycles = 16;   // long enough for the release to settle
  localparam int c_led_timeout    = 64;
  localparam int c_frame_timeout  = 12000;
  localparam int c_num_press      = 10;

  typedef struct packed {
    logic [6:0] btn;
    logic [7:0] hold;    // cycles held, glitch entries pick their own
    logic       counts;
  } press_t;

  logic       clkm;
  logic       reset;
  logic [6:0] btn;
  logic [7:0] led;
  logic       oled_clk;
  logic       oled_mosi;
  logic       oled_dc;
  logic       oled_resn;
  logic       oled_csn;

  press_t   press_tab [c_num_press];
  operand_t model_a = c_ma_init;
  operand_t model_b = c_mb_init;

  int led_errors  = 0;
  int spi_errors  = 0;
  int pin_errors  = 0;
  int timeouts    = 0;
  int frames_done = 0;

  // spi monitor state
  logic       in_frame   = 1'b0;
  int         frame_bits = 0;
  color_t     first_px   = '0;
  logic [7:0] cmd_byte   = '0;
  int         cmd_cnt    = 0;

  top_hex_mul #(
    .c_debounce_bits (c_debounce_bits),
    .c_width         (c_width),
    .c_height        (c_height)
  ) dut_i (
    .clkm      (clkm),
    .reset     (reset),
    .btn       (btn),
    .led       (led),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi),
    .oled_dc   (oled_dc),
    .oled_resn (oled_resn),
    .oled_csn  (oled_csn)
  );

  initial
  begin
    clkm = 1'b0;
    forever #20 clkm = ~clkm;
  end

  task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: led = %h, expected %h", $time, got, exp);
      led_errors++;
    end
  endtask

  task automatic check_color(input string sig, input color_t got, input color_t exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, sig, got, exp);
      spi_errors++;
    end
  endtask

  task automatic check_count(input string sig, input int got, input int exp);
    if (got != exp)
    begin
      $display("FAILED at %0t: %s = %0d, expected %0d", $time, sig, got, exp);
      spi_errors++;
    end
  endtask

  task automatic check_pin(input string sig, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s = %b, expected %b", $time, sig, got, exp);
      pin_errors++;
    end
  endtask

  // low byte of the signed product a * b
  function automatic logic [7:0] expected_led(input operand_t a, input operand_t b);
    longint full;
    full = longint'(a) * longint'(b);
    return full[7:0];
  endfunction

  task automatic load_press_table();
    press_tab[0] = '{btn: 7'b0001000, hold: 8'd16, counts: 1'b1}; // a up
    press_tab[1] = '{btn: 7'b0010000, hold: 8'd16, counts: 1'b1}; // a down
    press_tab[2] = '{btn: 7'b1000000, hold: 8'd16, counts: 1'b1}; // b up
    press_tab[3] = '{btn: 7'b0100000, hold: 8'd16, counts: 1'b1}; // b down
    press_tab[4] = '{btn: 7'b0011000, hold: 8'd16, counts: 1'b1}; // up wins
    press_tab[5] = '{btn: 7'b0001000, hold: 8'd0,  counts: 1'b0};
    press_tab[6] = '{btn: 7'b0010000, hold: 8'd20, counts: 1'b1};
    press_tab[7] = '{btn: 7'b1000000, hold: 8'd0,  counts: 1'b0};
    press_tab[8] = '{btn: 7'b1100000, hold: 8'd16, counts: 1'b1}; // up wins on b
    press_tab[9] = '{btn: 7'b0100000, hold: 8'd0,  counts: 1'b0};
  endtask

  task automatic apply_press(input logic [6:0] pattern, input int hold);
    @(posedge clkm);
    btn <= pattern;
    repeat (hold) @(posedge clkm);
    btn <= '0;
    repeat (c_release_cycles) @(posedge clkm);
  endtask

  task automatic wait_led(input logic [7:0] exp);
    int cyc;
    cyc = 0;
    @(negedge clkm);
    while (led !== exp && cyc < c_led_timeout)
    begin
      @(negedge clkm);
      cyc++;
    end
    if (cyc >= c_led_timeout)
    begin
      $display("timeout: led did not reach the expected product byte at %0t", $time);
      timeouts++;
    end
    check_led(led, exp);
  endtask

  // mode 3, bits are stable on the rising spi clock
  always @(posedge oled_clk)
  begin
    if (reset === 1'b0)
    begin
      if (oled_dc === 1'b0)
      begin
        if (in_frame)
        begin
          check_count("frame bits", frame_bits, c_frame_bits);
          check_color("first pixel", first_px, c_bg_color);
          frames_done++;
          in_frame = 1'b0;
        end
        cmd_byte = {cmd_byte[6:0], oled_mosi};
        cmd_cnt++;
        if (cmd_cnt == 8)
        begin
          if (cmd_byte == 8'h2c)
          begin
            in_frame   = 1'b1; // memory write, pixels follow
            frame_bits = 0;
          end
          cmd_cnt = 0;
        end
      end
      else
      begin
        cmd_cnt = 0;
        if (in_frame)
        begin
          if (frame_bits < 16)
            first_px = {first_px[14:0], oled_mosi};
          frame_bits++;
        end
      end
    end
  end

  always @(negedge clkm)
  begin
    check_pin("oled_csn", oled_csn, 1'b1);
  end

  initial
  begin
    int     i;
    int     hold;
    int     cyc;
    press_t entry;
    void'($urandom(68));
    reset = 1'b1;
    btn   = '0;
    load_press_table();

    // reset for 8 cycles, panel stays in reset 16 more
    for (i = 0; i < 24; i++)
    begin
      @(posedge clkm);
      if (i == 7)
        reset <= 1'b0;
      @(negedge clkm);
      if (i < 23)
      begin
        check_pin("oled_resn", oled_resn, 1'b0);
        check_pin("oled_clk", oled_clk, 1'b1);
      end
      else
        check_pin("oled_resn", oled_resn, 1'b1);
    end

    wait_led(expected_led(model_a, model_b));

    for (i = 0; i < c_num_press; i++)
    begin
      entry = press_tab[i];
      if (entry.counts)
        hold = int'(entry.hold);
      else
        hold = 1 + int'($urandom % 7); // always shorter than the debounce time
      apply_press(entry.btn, hold);
      if (entry.counts)
      begin
        if (entry.btn[3])
          model_a = model_a + 32'sd1;
        else if (entry.btn[4])
          model_a = model_a - 32'sd1;
        if (entry.btn[6])
          model_b = model_b + 32'sd1;
        else if (entry.btn[5])
          model_b = model_b - 32'sd1;
      end
      wait_led(expected_led(model_a, model_b));
    end

    // two whole frames from the spi monitor
    cyc = 0;
    while (frames_done < 2 && cyc < c_frame_timeout)
    begin
      @(negedge clkm);
      cyc++;
    end
    if (frames_done < 2)
    begin
      $display("timeout: only %0d complete frames seen on the spi pins", frames_done);
      timeouts++;
    end

    $display("led errors %0d, spi errors %0d, pin errors %0d, timeouts %0d",
             led_errors, spi_errors, pin_errors, timeouts);
    if (led_errors + spi_errors + pin_errors + timeouts == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== sources.f ====
common/hex_mul_pkg.sv
source/btn_debounce.sv
source/operand_multiplier.sv
hex_display/hex_decoder.sv
lcd/lcd_stream.sv
source/top_hex_mul.sv
dv/tb_top_hex_mul.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_top_hex_mul
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
